// File: Makefile
# Verilator build and run for the attribute interpolator testbench
TOP = tb_attrib_interp

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal --top-module $(TOP) -f compile.f -Mdir obj_dir

# Pass only when the pass message shows up in the simulation output
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

// File: attr_stream_pkg.sv
/* Attribute interpolator stream records
   Rasterizer pixel beat, triangle setup and the records between pipeline stages */
package attr_stream_pkg;

    import attr_types_pkg::*;

    // One value per channel, indexed by CH_R .. CH_Z
    typedef attr_t [NUM_CHANNELS-1:0] attr_vec_t;

    ////////////////////////////////////////
    // Pixel stream
    ////////////////////////////////////////

    // Fields carried through the pipeline unchanged
    typedef struct packed {
        screen_pos_t screen_x;
        screen_pos_t screen_y;
        fb_index_t   index;
        logic        last;
    } pixel_side_t;

    // Beat from the rasterizer
    typedef struct packed {
        screen_pos_t bb_x;
        screen_pos_t bb_y;
        pixel_side_t side;
    } pixel_beat_t;

    // Per-triangle setup, constant while pixels are in flight
    typedef struct packed {
        attr_vec_t base;
        attr_vec_t inc_x;
        attr_vec_t inc_y;
    } triangle_attr_t;

    ////////////////////////////////////////
    // Stage records
    ////////////////////////////////////////
    typedef struct packed {
        pixel_side_t side;
        attr_vec_t   prod_x;
        attr_vec_t   prod_y;
    } mul_out_t;

    typedef struct packed {
        pixel_side_t side;
        attr_vec_t   inc_sum;
    } sum_out_t;

    // Interpolated output beat
    typedef struct packed {
        pixel_side_t side;
        attr_vec_t   attr;
    } pixel_out_t;

endpackage

// File: attr_types_pkg.sv
/* Attribute interpolator numeric formats
   Coordinate, index and Q16.16 attribute widths plus the channel order */
package attr_types_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int SCREEN_POS_WIDTH = 11;
    localparam int INDEX_WIDTH      = 16;
    // Signed Q16.16, results wrap to this width
    localparam int ATTR_WIDTH       = 32;
    localparam int NUM_CHANNELS     = 5;

    ////////////////////////////////////////
    // Channel positions in every per-channel array
    ////////////////////////////////////////
    localparam int CH_R = 0;
    localparam int CH_G = 1;
    localparam int CH_B = 2;
    localparam int CH_A = 3;
    // Depth z
    localparam int CH_Z = 4;

    // Screen or bounding-box coordinate
    typedef logic [SCREEN_POS_WIDTH-1:0] screen_pos_t;

    // Framebuffer index
    typedef logic [INDEX_WIDTH-1:0] fb_index_t;

    // Attribute value or increment
    typedef logic signed [ATTR_WIDTH-1:0] attr_t;

endpackage

// File: attrib_interp.sv
/* Per-pixel attribute interpolator, three registered stages
   Computes base + bb_x * inc_x + bb_y * inc_y for each channel in fixed point */
module attrib_interp
    import attr_stream_pkg::*;
#(
    parameter int TRACK_WIDTH = 4
) (
    input  logic           aclk,
    input  logic           rst_n,

    // Pixel stream from the rasterizer, no back-pressure
    input  logic           s_valid,
    input  pixel_beat_t    s_beat,

    // Triangle setup
    input  triangle_attr_t tri_attr,

    // Interpolated pixel stream
    output logic           m_valid,
    output pixel_out_t     m_pixel,

    output logic           pixel_in_pipeline
);

    logic     mul_valid;
    mul_out_t mul_data;
    logic     sum_valid;
    sum_out_t sum_data;

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////
    interp_mul_stage mul_stage0 (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (s_valid),
        .in_beat   (s_beat),
        .tri_attr  (tri_attr),
        .out_valid (mul_valid),
        .out_data  (mul_data)
    );

    interp_sum_stage sum_stage0 (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (mul_valid),
        .in_data   (mul_data),
        .out_valid (sum_valid),
        .out_data  (sum_data)
    );

    interp_base_stage base_stage0 (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (sum_valid),
        .in_data   (sum_data),
        .tri_attr  (tri_attr),
        .out_valid (m_valid),
        .out_pixel (m_pixel)
    );

    ////////////////////////////////////////
    // Busy tracking
    ////////////////////////////////////////
    pixel_tracker #(
        .TRACK_WIDTH (TRACK_WIDTH)
    ) tracker0 (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .incoming    (s_valid),
        .outgoing    (m_valid),
        .in_pipeline (pixel_in_pipeline)
    );

endmodule

// File: compile.f
+incdir+.
attr_types_pkg.sv
attr_stream_pkg.sv
interp_mul_stage.sv
interp_sum_stage.sv
interp_base_stage.sv
pixel_tracker.sv
attrib_interp.sv
tb_attrib_interp.sv

// File: interp_base_stage.sv
/* Interpolator stage 3
   Adds the triangle base to the summed increment and registers the output beat */
module interp_base_stage
    import attr_types_pkg::*;
    import attr_stream_pkg::*;
(
    input  logic           aclk,
    input  logic           rst_n,

    input  logic           in_valid,
    input  sum_out_t       in_data,

    // Triangle setup, only the bases are read here
    input  triangle_attr_t tri_attr,

    // Interpolated pixel stream
    output logic           out_valid,
    output pixel_out_t     out_pixel
);

    ////////////////////////////////////////
    // Output valid
    ////////////////////////////////////////
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    ////////////////////////////////////////
    // Final attribute values
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        out_pixel.side <= in_data.side;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            out_pixel.attr[ch] <= tri_attr.base[ch] + in_data.inc_sum[ch];
        end
    end

endmodule

// File: interp_mul_stage.sv
/* Interpolator stage 1
   Multiplies the bounding-box offsets by each channel's x and y increments */
module interp_mul_stage
    import attr_types_pkg::*;
    import attr_stream_pkg::*;
(
    input  logic           aclk,
    input  logic           rst_n,

    // Rasterizer beat
    input  logic           in_valid,
    input  pixel_beat_t    in_beat,

    // Triangle setup, only the increments are read here
    input  triangle_attr_t tri_attr,

    output logic           out_valid,
    output mul_out_t       out_data
);

    localparam int PAD_WIDTH = ATTR_WIDTH - SCREEN_POS_WIDTH;

    // Bounding-box offsets widened to the attribute format
    // These are integer factors, not Q16.16 values
    attr_t bb_x_ext;
    attr_t bb_y_ext;

    assign bb_x_ext = {{PAD_WIDTH{1'b0}}, in_beat.bb_x};
    assign bb_y_ext = {{PAD_WIDTH{1'b0}}, in_beat.bb_y};

    ////////////////////////////////////////
    // Valid
    ////////////////////////////////////////
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    ////////////////////////////////////////
    // Products and sideband
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        // Bounding-box fields end here
        out_data.side <= in_beat.side;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            // Low word of the product, integer times Q16.16 stays Q16.16
            out_data.prod_x[ch] <= bb_x_ext * tri_attr.inc_x[ch];
            out_data.prod_y[ch] <= bb_y_ext * tri_attr.inc_y[ch];
        end
    end

endmodule

// File: interp_sum_stage.sv
/* Interpolator stage 2
   Adds the x and y increment products of each channel */
module interp_sum_stage
    import attr_types_pkg::*;
    import attr_stream_pkg::*;
(
    input  logic     aclk,
    input  logic     rst_n,

    input  logic     in_valid,
    input  mul_out_t in_data,

    output logic     out_valid,
    output sum_out_t out_data
);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    ////////////////////////////////////////
    // Total increment per channel
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        out_data.side <= in_data.side;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            // Wraps at 32 bits, carry out is dropped
            out_data.inc_sum[ch] <= in_data.prod_x[ch] + in_data.prod_y[ch];
        end
    end

endmodule

// File: pixel_tracker.sv
/* Pixel tracker
   Counts beats accepted but not yet emitted and flags a busy pipeline */
module pixel_tracker #(
    parameter int TRACK_WIDTH = 4
) (
    input  logic aclk,
    input  logic rst_n,

    input  logic incoming,
    input  logic outgoing,
    output logic in_pipeline
);

    logic [TRACK_WIDTH-1:0] count;
    logic [TRACK_WIDTH-1:0] count_next;

    // Entry and exit in the same cycle cancel out
    always_comb begin
        count_next = count;
        if (incoming && !outgoing) begin
            count_next = count + 1'b1;
        end else if (outgoing && !incoming) begin
            count_next = count - 1'b1;
        end
    end

    // Flag follows the next count so it tracks the counter without lag
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            count       <= '0;
            in_pipeline <= 1'b0;
        end else begin
            count       <= count_next;
            in_pipeline <= (count_next != '0);
        end
    end

endmodule

// File: tb_attrib_model.svh
/* Attribute interpolator testbench model
   LFSR stimulus source, reference interpolation and result checks */
`ifndef TB_ATTRIB_MODEL_SVH
`define TB_ATTRIB_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'd89446;
// Galois feedback mask, taps 32 22 2 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state = LFSR_SEED;

////////////////////////////////////////
// Random source
////////////////////////////////////////
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next_state;
    next_state = state >> 1;
    if (state[0]) begin
        next_state = next_state ^ LFSR_TAPS;
    end
    return next_state;
endfunction

// One LFSR step per bit, first bit ends up as the MSB of the result
function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] result;
    result = '0;
    for (int i = 0; i < count; i++) begin
        result     = {result[30:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
    return result;
endfunction

function automatic triangle_attr_t random_setup();
    triangle_attr_t setup;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        setup.base[ch]  = attr_t'(rand_bits(ATTR_WIDTH));
        setup.inc_x[ch] = attr_t'(rand_bits(ATTR_WIDTH));
        setup.inc_y[ch] = attr_t'(rand_bits(ATTR_WIDTH));
    end
    return setup;
endfunction

function automatic pixel_beat_t random_beat();
    pixel_beat_t beat;
    beat.bb_x          = screen_pos_t'(rand_bits(SCREEN_POS_WIDTH));
    beat.bb_y          = screen_pos_t'(rand_bits(SCREEN_POS_WIDTH));
    beat.side.screen_x = screen_pos_t'(rand_bits(SCREEN_POS_WIDTH));
    beat.side.screen_y = screen_pos_t'(rand_bits(SCREEN_POS_WIDTH));
    beat.side.index    = fb_index_t'(rand_bits(INDEX_WIDTH));
    beat.side.last     = rand_bits(1) != 0;
    return beat;
endfunction

////////////////////////////////////////
// Reference model
////////////////////////////////////////
// Full precision sum in 64 bits, then keep the low attribute word
function automatic pixel_out_t model_pixel(input pixel_beat_t beat,
                                           input triangle_attr_t setup);
    pixel_out_t expected;
    longint     bx;
    longint     by;
    longint     total;
    bx = longint'(beat.bb_x);
    by = longint'(beat.bb_y);
    expected.side = beat.side;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        total = longint'($signed(setup.base[ch]))
              + bx * longint'($signed(setup.inc_x[ch]))
              + by * longint'($signed(setup.inc_y[ch]));
        expected.attr[ch] = total[ATTR_WIDTH-1:0];
    end
    return expected;
endfunction

function automatic string channel_name(input int ch);
    case (ch)
        CH_R:    return "r";
        CH_G:    return "g";
        CH_B:    return "b";
        CH_A:    return "a";
        default: return "z";
    endcase
endfunction

////////////////////////////////////////
// Checks
////////////////////////////////////////
task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (expected !== actual) begin
        report_failure($sformatf("FAILED %s expected %0h actual %0h",
                                 name, expected, actual));
    end
endtask

`endif

// File: tb_attrib_interp.sv
/* Attribute interpolator testbench
   Random pixel streams against a reference model with latency and busy checks */
module tb_attrib_interp
    import attr_types_pkg::*;
    import attr_stream_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES    = 8;
    localparam int IDLE_CYCLES     = 10;
    localparam int BURST_LEN       = 200;
    localparam int GAP_CYCLES      = 300;
    localparam int SETUP_BURSTS    = 3;
    localparam int SETUP_BURST_LEN = 50;
    localparam int EXTREME_SETUPS  = 2;
    localparam int EXTREME_LEN     = 100;
    // Cycles from driving a beat on the falling edge to seeing it on the output
    localparam int LATENCY         = 3;

    localparam int STIM_CYCLES = RESET_CYCLES + IDLE_CYCLES + 1 + BURST_LEN + GAP_CYCLES
                               + SETUP_BURSTS * SETUP_BURST_LEN
                               + EXTREME_SETUPS * EXTREME_LEN;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 100;

    logic           aclk;
    logic           rst_n;
    logic           s_valid;
    pixel_beat_t    s_beat;
    triangle_attr_t tri_attr;
    logic           m_valid;
    pixel_out_t     m_pixel;
    logic           pixel_in_pipeline;

    // Scoreboard of expected beats and the cycle each one is due
    pixel_out_t expected_q[$];
    int         due_q[$];
    int         cycle_count = 0;
    string      current_test = "reset";

    `include "tb_attrib_model.svh"

    attrib_interp #(
        .TRACK_WIDTH (4)
    ) dut0 (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .s_valid           (s_valid),
        .s_beat            (s_beat),
        .tri_attr          (tri_attr),
        .m_valid           (m_valid),
        .m_pixel           (m_pixel),
        .pixel_in_pipeline (pixel_in_pipeline)
    );

    always #5 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("Timeout, the run did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////
    // Cycle driver and monitor
    ////////////////////////////////////////
    // Outputs are checked on the falling edge before the new inputs go out
    task automatic step_cycle(input logic valid, input pixel_beat_t beat);
        pixel_out_t expected;
        int         due;
        @(negedge aclk);
        check_value({current_test, "_busy"}, 64'(expected_q.size() != 0),
                    64'(pixel_in_pipeline));
        if (m_valid) begin
            if (expected_q.size() == 0) begin
                report_failure("Output beat arrived with no input beat pending");
            end else begin
                expected = expected_q.pop_front();
                due      = due_q.pop_front();
                check_value({current_test, "_latency"}, 64'(due), 64'(cycle_count));
                check_value({current_test, "_side"}, 64'(expected.side), 64'(m_pixel.side));
                for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                    check_value({current_test, "_ch_", channel_name(ch)},
                                64'(expected.attr[ch]), 64'(m_pixel.attr[ch]));
                end
            end
        end
        s_valid = valid;
        s_beat  = beat;
        if (valid) begin
            expected_q.push_back(model_pixel(beat, tri_attr));
            due_q.push_back(cycle_count + LATENCY);
        end
    endtask

    task automatic wait_idle();
        do begin
            step_cycle(1'b0, '0);
        end while (pixel_in_pipeline);
    endtask

    // Negative increments and bases close to both ends of the signed range
    function automatic triangle_attr_t extreme_setup();
        triangle_attr_t setup;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (ch % 2 == 0) begin
                setup.base[ch] = attr_t'(32'h7FFF_FF00 | rand_bits(8));
            end else begin
                setup.base[ch] = attr_t'(32'h8000_0000 | rand_bits(8));
            end
            setup.inc_x[ch] = attr_t'(32'h8000_0000 | rand_bits(31));
            setup.inc_y[ch] = attr_t'(32'hFFF0_0000 | rand_bits(20));
        end
        return setup;
    endfunction

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        pixel_beat_t beat;
        logic        valid;
        aclk     = 1'b0;
        rst_n    = 1'b0;
        s_valid  = 1'b0;
        s_beat   = '0;
        tri_attr = '0;
        repeat (RESET_CYCLES) @(negedge aclk);
        rst_n = 1'b1;

        current_test = "reset_idle";
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            step_cycle(1'b0, '0);
            check_value("reset_idle_m_valid", 64'd0, 64'(m_valid));
        end

        current_test = "single_beat";
        tri_attr = random_setup();
        step_cycle(1'b1, random_beat());
        wait_idle();

        current_test = "full_burst";
        for (int i = 0; i < BURST_LEN; i++) begin
            step_cycle(1'b1, random_beat());
        end
        wait_idle();

        current_test = "random_gaps";
        for (int i = 0; i < GAP_CYCLES; i++) begin
            valid = rand_bits(1) != 0;
            step_cycle(valid, random_beat());
        end
        wait_idle();

        // New setup is only loaded once the pipeline has drained
        current_test = "setup_change";
        for (int s = 0; s < SETUP_BURSTS; s++) begin
            tri_attr = random_setup();
            for (int i = 0; i < SETUP_BURST_LEN; i++) begin
                step_cycle(1'b1, random_beat());
            end
            wait_idle();
        end

        current_test = "extreme_values";
        for (int s = 0; s < EXTREME_SETUPS; s++) begin
            tri_attr = extreme_setup();
            for (int i = 0; i < EXTREME_LEN; i++) begin
                beat = random_beat();
                if (rand_bits(1) != 0) begin
                    beat.bb_x = '1;
                    beat.bb_y = '1;
                end
                step_cycle(1'b1, beat);
            end
            wait_idle();
        end

        $display("all tests passed");
        $finish;
    end

endmodule
